//--- Bender.yml
package:
  name: pipe_slice

sources:
  - source/pipe_pkg.sv
  - source/exec_ctrl_if.sv
  - source/issue_control.sv
  - source/execute_unit.sv
  - source/execute_ctrl_stage.sv
  - source/lsu_unit.sv
  - source/spr_unit.sv
  - source/pipe_slice_top.sv
  - target: simulation
    files:
      - verif/pipe_slice_tb.sv

//--- filelist.f
source/pipe_pkg.sv
source/exec_ctrl_if.sv
source/issue_control.sv
source/execute_unit.sv
source/execute_ctrl_stage.sv
source/lsu_unit.sv
source/spr_unit.sv
source/pipe_slice_top.sv
verif/pipe_slice_tb.sv

//--- source/exec_ctrl_if.sv
// interfaces: execute to control stage, load/store requests, spr requests
interface exec_ctrl_if;
   import pipe_pkg::*;
   logic     valid;
   op_e      op;
   reg_adr_t rd;
   logic     wb;
   word_t    result;
   word_t    lsu_adr;
   word_t    store_data;
   word_t    pc;
   exc_e     exc;
   modport exec (output valid, op, rd, wb, result, lsu_adr, store_data, pc, exc);
   modport ctrl (input valid, op, rd, wb, result, lsu_adr, store_data, pc, exc);
endinterface

interface lsu_if;
   import pipe_pkg::*;
   logic  req, we, valid;
   word_t adr, wdata, rdata;
   modport ctrl (output req, we, adr, wdata, input valid, rdata);
   modport lsu (input req, we, adr, wdata, output valid, rdata);
endinterface

interface spr_if;
   import pipe_pkg::*;
   logic     req, we, ack;
   spr_adr_t adr;
   word_t    wdata, rdata;
   modport ctrl (output req, we, adr, wdata, input ack, rdata);
   modport spr (input req, we, adr, wdata, output ack, rdata);
endinterface

//--- source/execute_ctrl_stage.sv
// execute to control stage register, stall logic, flag register and writeback slot
module execute_ctrl_stage (
   input  logic               clk,
   input  logic               rst,
   input  logic               padv_i,
   input  logic               flush_i,
   exec_ctrl_if.ctrl          ex,
   lsu_if.ctrl                lsu,
   spr_if.ctrl                spr,
   output logic               ctrl_valid_o,
   output logic               exc_taken_o,
   output logic               retire_valid_o,
   output pipe_pkg::word_t    retire_pc_o,
   output logic               retire_wb_o,
   output pipe_pkg::reg_adr_t retire_rd_o,
   output pipe_pkg::word_t    retire_data_o,
   output logic               retire_flag_o,
   output logic               exc_valid_o,
   output pipe_pkg::exc_e     exc_cause_o,
   output pipe_pkg::word_t    exc_pc_o
);
   import pipe_pkg::*;

   logic     ctrl_vld;
   op_e      ctrl_op;
   exc_e     ctrl_exc;
   logic     ctrl_wb;
   reg_adr_t ctrl_rd;
   word_t    ctrl_result;
   word_t    ctrl_adr;
   word_t    ctrl_sdata;
   word_t    pc_ctrl;
   logic     flag_q;
   logic     ctrl_stall;
   logic     complete;
   word_t    wb_data;

   // padv has priority so an instruction arriving with the flush is kept
   always_ff @(posedge clk) begin
      if (rst) begin
         ctrl_vld <= 1'b0;
         ctrl_op  <= OP_ADD;
         ctrl_exc <= EXC_NONE;
         ctrl_wb  <= 1'b0;
      end else if (padv_i) begin
         ctrl_vld <= ex.valid;
         ctrl_op  <= ex.op;
         ctrl_exc <= ex.exc;
         ctrl_wb  <= ex.wb;
      end else if (flush_i) begin
         ctrl_vld <= 1'b0;
         ctrl_wb  <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (padv_i) begin
         ctrl_rd     <= ex.rd;
         ctrl_result <= ex.result;
         ctrl_adr    <= ex.lsu_adr;
         ctrl_sdata  <= ex.store_data;
      end
   end

   // bubbles leave the pc alone
   always_ff @(posedge clk) begin
      if (rst) begin
         pc_ctrl <= RESET_PC;
      end else if (padv_i && ex.valid) begin
         pc_ctrl <= ex.pc;
      end
   end

   // excepting loads/stores never reach the memory
   assign lsu.req   = ctrl_vld && (ctrl_exc == EXC_NONE) &&
                      ((ctrl_op == OP_LW) || (ctrl_op == OP_SW));
   assign lsu.we    = (ctrl_op == OP_SW);
   assign lsu.adr   = ctrl_adr;
   assign lsu.wdata = ctrl_sdata;
   assign spr.req   = ctrl_vld && ((ctrl_op == OP_MFSPR) || (ctrl_op == OP_MTSPR));
   assign spr.we    = (ctrl_op == OP_MTSPR);
   assign spr.adr   = ctrl_adr[2:0];
   assign spr.wdata = ctrl_sdata;

   assign ctrl_stall   = (lsu.req && !lsu.valid) || (spr.req && !spr.ack);
   assign ctrl_valid_o = !ctrl_stall;
   assign complete     = ctrl_vld && !ctrl_stall;
   assign exc_taken_o  = complete && (ctrl_exc != EXC_NONE);

   always_ff @(posedge clk) begin
      if (rst) begin
         flag_q <= 1'b0;
      end else if (complete && (ctrl_op == OP_SFEQ)) begin
         flag_q <= ctrl_result[0];
      end
   end

   // flag value after the retiring instruction
   assign retire_flag_o = flag_q;

   always_comb begin
      case (ctrl_op)
         OP_LW:    wb_data = lsu.rdata;
         OP_MFSPR: wb_data = spr.rdata;
         default:  wb_data = ctrl_result;
      endcase
   end

   // wb is sampled only in the completion cycle, so a long access writes back once
   always_ff @(posedge clk) begin
      if (rst) begin
         retire_valid_o <= 1'b0;
         retire_wb_o    <= 1'b0;
         exc_valid_o    <= 1'b0;
      end else begin
         retire_valid_o <= complete && (ctrl_exc == EXC_NONE);
         retire_wb_o    <= complete && ctrl_wb && (ctrl_exc == EXC_NONE);
         exc_valid_o    <= exc_taken_o;
      end
   end

   always_ff @(posedge clk) begin
      if (complete) begin
         retire_pc_o   <= pc_ctrl;
         retire_rd_o   <= ctrl_rd;
         retire_data_o <= wb_data;
         exc_cause_o   <= ctrl_exc;
         exc_pc_o      <= pc_ctrl;
      end
   end

   // younger work is flushed, so nothing retires right behind an exception
   a_exc_flush: assert property (@(posedge clk) disable iff (rst)
      exc_valid_o |=> !retire_valid_o);

endmodule

//--- source/execute_unit.sv
// execute stage: alu, address adder, link address and alignment check
module execute_unit (
   input  logic               head_valid_i,
   input  pipe_pkg::op_e      head_op_i,
   input  pipe_pkg::reg_adr_t head_rd_i,
   input  pipe_pkg::word_t    head_a_i,
   input  pipe_pkg::word_t    head_b_i,
   input  pipe_pkg::word_t    head_imm_i,
   input  pipe_pkg::word_t    head_pc_i,
   exec_ctrl_if.exec          ex
);
   import pipe_pkg::*;

   word_t adder;
   logic  mem_op;

   // also used as the spr index for mfspr/mtspr
   assign adder  = head_a_i + head_imm_i;
   assign mem_op = (head_op_i == OP_LW) || (head_op_i == OP_SW);

   always_comb begin
      case (head_op_i)
         OP_ADD:  ex.result = head_a_i + head_b_i;
         OP_SUB:  ex.result = head_a_i - head_b_i;
         OP_AND:  ex.result = head_a_i & head_b_i;
         OP_OR:   ex.result = head_a_i | head_b_i;
         OP_XOR:  ex.result = head_a_i ^ head_b_i;
         OP_SFEQ: ex.result = {31'b0, head_a_i == head_b_i};
         // link address
         OP_JAL:  ex.result = head_pc_i + 32'd4;
         default: ex.result = '0;
      endcase
   end

   always_comb begin
      case (head_op_i)
         OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR: ex.wb = 1'b1;
         OP_JAL, OP_LW, OP_MFSPR:               ex.wb = 1'b1;
         default:                               ex.wb = 1'b0;
      endcase
   end

   always_comb begin
      if (head_op_i == OP_TRAP) begin
         ex.exc = EXC_TRAP;
      end else if (mem_op && (adder[1:0] != 2'b00)) begin
         ex.exc = EXC_ALIGN;
      end else begin
         ex.exc = EXC_NONE;
      end
   end

   assign ex.valid      = head_valid_i;
   assign ex.op         = head_op_i;
   assign ex.rd         = head_rd_i;
   assign ex.pc         = head_pc_i;
   assign ex.lsu_adr    = adder;
   assign ex.store_data = head_b_i;

endmodule

//--- source/issue_control.sv
// issue queue with credit return, pipeline advance and flush generation
module issue_control #(
   parameter int QUEUE_DEPTH = 2
) (
   input  logic               clk,
   input  logic               rst,
   input  logic               issue_valid_i,
   input  pipe_pkg::op_e      issue_op_i,
   input  pipe_pkg::reg_adr_t issue_rd_i,
   input  pipe_pkg::word_t    issue_a_i,
   input  pipe_pkg::word_t    issue_b_i,
   input  pipe_pkg::word_t    issue_imm_i,
   input  pipe_pkg::word_t    issue_pc_i,
   input  logic               ctrl_valid_i,
   input  logic               exc_taken_i,
   output logic               credit_o,
   output logic               padv_o,
   output logic               flush_o,
   output logic               head_valid_o,
   output pipe_pkg::op_e      head_op_o,
   output pipe_pkg::reg_adr_t head_rd_o,
   output pipe_pkg::word_t    head_a_o,
   output pipe_pkg::word_t    head_b_o,
   output pipe_pkg::word_t    head_imm_o,
   output pipe_pkg::word_t    head_pc_o
);
   import pipe_pkg::*;

   localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
   localparam int CNT_W = $clog2(QUEUE_DEPTH + 1) + 1;

   op_e      q_op  [QUEUE_DEPTH];
   reg_adr_t q_rd  [QUEUE_DEPTH];
   word_t    q_a   [QUEUE_DEPTH];
   word_t    q_b   [QUEUE_DEPTH];
   word_t    q_imm [QUEUE_DEPTH];
   word_t    q_pc  [QUEUE_DEPTH];

   logic [PTR_W-1:0] rd_ptr;
   logic [PTR_W-1:0] wr_ptr;
   logic [CNT_W-1:0] count;
   logic [CNT_W-1:0] pending;
   logic [CNT_W-1:0] returned;
   logic [CNT_W-1:0] credit_sum;
   logic             empty;
   logic             pop;

   assign padv_o  = ctrl_valid_i;
   assign flush_o = exc_taken_i;
   assign empty   = (count == '0);
   assign pop     = padv_o && !empty && !flush_o;

   // younger work is killed here, so execute sees a bubble during a flush
   assign head_valid_o = !empty && !flush_o;
   assign head_op_o    = q_op[rd_ptr];
   assign head_rd_o    = q_rd[rd_ptr];
   assign head_a_o     = q_a[rd_ptr];
   assign head_b_o     = q_b[rd_ptr];
   assign head_imm_o   = q_imm[rd_ptr];
   assign head_pc_o    = q_pc[rd_ptr];

   // a flush discards every entry, including one written in the same cycle
   assign returned   = flush_o ? count + CNT_W'(issue_valid_i) : CNT_W'(pop);
   assign credit_sum = pending + returned;

   always_ff @(posedge clk) begin
      if (rst || flush_o) begin
         rd_ptr <= '0;
         wr_ptr <= '0;
         count  <= '0;
      end else begin
         if (issue_valid_i) begin
            wr_ptr <= (wr_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= (rd_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         end
         count <= count + CNT_W'(issue_valid_i) - CNT_W'(pop);
      end
   end

   always_ff @(posedge clk) begin
      if (issue_valid_i && !flush_o) begin
         q_op[wr_ptr]  <= issue_op_i;
         q_rd[wr_ptr]  <= issue_rd_i;
         q_a[wr_ptr]   <= issue_a_i;
         q_b[wr_ptr]   <= issue_b_i;
         q_imm[wr_ptr] <= issue_imm_i;
         q_pc[wr_ptr]  <= issue_pc_i;
      end
   end

   // one credit per cycle, the rest wait in pending
   always_ff @(posedge clk) begin
      if (rst) begin
         pending  <= '0;
         credit_o <= 1'b0;
      end else begin
         credit_o <= (credit_sum != '0);
         pending  <= (credit_sum == '0) ? '0 : credit_sum - 1'b1;
      end
   end

   // the issuer only sends with a credit in hand
   a_no_overflow: assert property (@(posedge clk) disable iff (rst)
      issue_valid_i |-> (count < CNT_W'(QUEUE_DEPTH)));

endmodule

//--- source/lsu_unit.sv
// word data memory answering requests after a pseudo-random latency
module lsu_unit #(
   parameter int MEM_WORDS = 64
) (
   input logic clk,
   input logic rst,
   lsu_if.lsu  lsu
);
   import pipe_pkg::*;

   localparam int IDX_W = $clog2(MEM_WORDS);

   word_t            mem [MEM_WORDS];
   logic [1:0]       lfsr;
   logic [2:0]       wait_cnt;
   logic             busy;
   logic [IDX_W-1:0] idx;

   // adr and wdata are held by the requester until valid
   assign idx       = lsu.adr[IDX_W+1:2];
   assign lsu.valid = busy && (wait_cnt == 3'd1);
   assign lsu.rdata = mem[idx];

   // x^2 + x + 1, steps through 1, 3, 2
   always_ff @(posedge clk) begin
      if (rst) begin
         lfsr <= 2'b01;
      end else begin
         lfsr <= {lfsr[0], lfsr[1] ^ lfsr[0]};
      end
   end

   // latency of 1, 3 or 4 cycles
   always_ff @(posedge clk) begin
      if (rst) begin
         busy     <= 1'b0;
         wait_cnt <= '0;
      end else if (!busy) begin
         if (lsu.req) begin
            busy     <= 1'b1;
            wait_cnt <= 3'(lfsr) + 3'(lfsr[1]);
         end
      end else if (lsu.valid) begin
         busy <= 1'b0;
      end else begin
         wait_cnt <= wait_cnt - 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] <= '0;
         end
      end else if (lsu.valid && lsu.we) begin
         mem[idx] <= lsu.wdata;
      end
   end

   // the request was already held in the cycle before its answer
   a_valid_req: assert property (@(posedge clk) disable iff (rst)
      lsu.valid |-> lsu.req && $past(lsu.req));

endmodule

//--- source/pipe_pkg.sv
// pipeline slice package: width typedefs, opcode and exception enums, reset pc
package pipe_pkg;

   typedef logic [31:0] word_t;
   typedef logic [4:0]  reg_adr_t;
   typedef logic [2:0]  spr_adr_t;

   typedef enum logic [3:0] {
      OP_ADD   = 4'h0,
      OP_SUB   = 4'h1,
      OP_AND   = 4'h2,
      OP_OR    = 4'h3,
      OP_XOR   = 4'h4,
      OP_SFEQ  = 4'h5,
      OP_JAL   = 4'h6,
      OP_LW    = 4'h7,
      OP_SW    = 4'h8,
      OP_MFSPR = 4'h9,
      OP_MTSPR = 4'ha,
      OP_TRAP  = 4'hb
   } op_e;

   typedef enum logic [1:0] {
      EXC_NONE  = 2'd0,
      EXC_ALIGN = 2'd1,
      EXC_TRAP  = 2'd2
   } exc_e;

   localparam word_t RESET_PC = 32'h0000_0100;

endpackage

//--- source/pipe_slice_top.sv
// slice top: issue queue, execute, control stage, data memory and spr file
module pipe_slice_top #(
   parameter int QUEUE_DEPTH = 2,
   parameter int MEM_WORDS   = 64,
   parameter int SPR_LATENCY = 2
) (
   input  logic               clk,
   input  logic               rst,
   input  logic               issue_valid_i,
   input  pipe_pkg::op_e      issue_op_i,
   input  pipe_pkg::reg_adr_t issue_rd_i,
   input  pipe_pkg::word_t    issue_a_i,
   input  pipe_pkg::word_t    issue_b_i,
   input  pipe_pkg::word_t    issue_imm_i,
   input  pipe_pkg::word_t    issue_pc_i,
   output logic               credit_o,
   output logic               retire_valid_o,
   output pipe_pkg::word_t    retire_pc_o,
   output logic               retire_wb_o,
   output pipe_pkg::reg_adr_t retire_rd_o,
   output pipe_pkg::word_t    retire_data_o,
   output logic               retire_flag_o,
   output logic               exc_valid_o,
   output pipe_pkg::exc_e     exc_cause_o,
   output pipe_pkg::word_t    exc_pc_o
);
   import pipe_pkg::*;

   logic     padv;
   logic     flush;
   logic     ctrl_valid;
   logic     exc_taken;
   logic     head_valid;
   op_e      head_op;
   reg_adr_t head_rd;
   word_t    head_a;
   word_t    head_b;
   word_t    head_imm;
   word_t    head_pc;

   exec_ctrl_if ex_bus ();
   lsu_if       lsu_bus ();
   spr_if       spr_bus ();

   issue_control #(
      .QUEUE_DEPTH (QUEUE_DEPTH)
   ) u_issue_control (
      .clk           (clk),
      .rst           (rst),
      .issue_valid_i (issue_valid_i),
      .issue_op_i    (issue_op_i),
      .issue_rd_i    (issue_rd_i),
      .issue_a_i     (issue_a_i),
      .issue_b_i     (issue_b_i),
      .issue_imm_i   (issue_imm_i),
      .issue_pc_i    (issue_pc_i),
      .ctrl_valid_i  (ctrl_valid),
      .exc_taken_i   (exc_taken),
      .credit_o      (credit_o),
      .padv_o        (padv),
      .flush_o       (flush),
      .head_valid_o  (head_valid),
      .head_op_o     (head_op),
      .head_rd_o     (head_rd),
      .head_a_o      (head_a),
      .head_b_o      (head_b),
      .head_imm_o    (head_imm),
      .head_pc_o     (head_pc)
   );

   execute_unit u_execute_unit (
      .head_valid_i (head_valid),
      .head_op_i    (head_op),
      .head_rd_i    (head_rd),
      .head_a_i     (head_a),
      .head_b_i     (head_b),
      .head_imm_i   (head_imm),
      .head_pc_i    (head_pc),
      .ex           (ex_bus.exec)
   );

   execute_ctrl_stage u_execute_ctrl_stage (
      .clk            (clk),
      .rst            (rst),
      .padv_i         (padv),
      .flush_i        (flush),
      .ex             (ex_bus.ctrl),
      .lsu            (lsu_bus.ctrl),
      .spr            (spr_bus.ctrl),
      .ctrl_valid_o   (ctrl_valid),
      .exc_taken_o    (exc_taken),
      .retire_valid_o (retire_valid_o),
      .retire_pc_o    (retire_pc_o),
      .retire_wb_o    (retire_wb_o),
      .retire_rd_o    (retire_rd_o),
      .retire_data_o  (retire_data_o),
      .retire_flag_o  (retire_flag_o),
      .exc_valid_o    (exc_valid_o),
      .exc_cause_o    (exc_cause_o),
      .exc_pc_o       (exc_pc_o)
   );

   lsu_unit #(
      .MEM_WORDS (MEM_WORDS)
   ) u_lsu_unit (
      .clk (clk),
      .rst (rst),
      .lsu (lsu_bus.lsu)
   );

   spr_unit #(
      .SPR_LATENCY (SPR_LATENCY)
   ) u_spr_unit (
      .clk (clk),
      .rst (rst),
      .spr (spr_bus.spr)
   );

endmodule

//--- source/spr_unit.sv
// special-purpose register file with a fixed ack latency
module spr_unit #(
   parameter int SPR_LATENCY = 2
) (
   input logic clk,
   input logic rst,
   spr_if.spr  spr
);
   import pipe_pkg::*;

   localparam int SPR_NUM = 2 ** $bits(spr_adr_t);
   localparam int CNT_W   = $clog2(SPR_LATENCY + 1);

   word_t            regs [SPR_NUM];
   logic             busy;
   logic [CNT_W-1:0] cnt;

   assign spr.ack   = busy && (cnt == CNT_W'(1));
   assign spr.rdata = regs[spr.adr];

   always_ff @(posedge clk) begin
      if (rst) begin
         busy <= 1'b0;
         cnt  <= '0;
      end else if (!busy) begin
         if (spr.req) begin
            busy <= 1'b1;
            cnt  <= CNT_W'(SPR_LATENCY);
         end
      end else if (spr.ack) begin
         busy <= 1'b0;
      end else begin
         cnt <= cnt - 1'b1;
      end
   end

   // mtspr takes effect with the ack
   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < SPR_NUM; i++) begin
            regs[i] <= '0;
         end
      end else if (spr.ack && spr.we) begin
         regs[spr.adr] <= spr.wdata;
      end
   end

endmodule

//--- verif/pipe_slice_cases.txt
// op rd a b imm pc kind data flag cause (hex)
// kind 0 retire with writeback, 1 retire without writeback, 2 exception
0 01 00000005 00000007 00000000 00000100 0 0000000c 0 0
1 02 00000010 00000003 00000000 00000104 0 0000000d 0 0
2 03 f0f0ff00 0ff0f0f0 00000000 00000108 0 00f0f000 0 0
3 04 12340000 00005678 00000000 0000010c 0 12345678 0 0
4 05 ffff0000 0f0f0f0f 00000000 00000110 0 f0f00f0f 0 0
5 00 0000002a 0000002a 00000000 00000114 1 00000000 1 0
6 09 00000000 00000000 00000000 00000118 0 0000011c 1 0
5 00 00000001 00000002 00000000 0000011c 1 00000000 0 0
8 00 00000010 deadbeef 00000004 00000120 1 00000000 0 0
7 06 00000010 00000000 00000004 00000124 0 deadbeef 0 0
7 07 00000020 00000000 00000000 00000128 0 00000000 0 0
a 00 00000000 cafef00d 00000003 0000012c 1 00000000 0 0
9 08 00000000 00000000 00000003 00000130 0 cafef00d 0 0
7 0a 00000010 00000000 00000002 00000134 2 00000000 0 1
0 0b 00000001 00000001 00000000 00000138 0 00000002 0 0
8 00 00000011 12345678 00000000 0000013c 2 00000000 0 1
b 00 00000000 00000000 00000000 00000140 2 00000000 0 2
4 0c a5a5a5a5 5a5a5a5a 00000000 00000144 0 ffffffff 0 0

//--- verif/pipe_slice_tb.sv
// testbench for the pipeline slice: clock, reset, credit-based issuer, retire monitor, checks
module pipe_slice_tb;
   import pipe_pkg::*;

   localparam int QUEUE_DEPTH    = 2;
   localparam int NUM_CASES      = 18;
   localparam int CASE_FIELDS    = 10;
   localparam int TIMEOUT_CYCLES = 200;

   // columns of one line in the cases file
   localparam int COL_OP    = 0;
   localparam int COL_RD    = 1;
   localparam int COL_A     = 2;
   localparam int COL_B     = 3;
   localparam int COL_IMM   = 4;
   localparam int COL_PC    = 5;
   localparam int COL_KIND  = 6;
   localparam int COL_DATA  = 7;
   localparam int COL_FLAG  = 8;
   localparam int COL_CAUSE = 9;

   // event kinds
   localparam logic [31:0] KIND_WB   = 32'd0;
   localparam logic [31:0] KIND_NOWB = 32'd1;
   localparam logic [31:0] KIND_EXC  = 32'd2;

   logic     clk;
   logic     rst;
   logic     issue_valid;
   op_e      issue_op;
   reg_adr_t issue_rd;
   word_t    issue_a;
   word_t    issue_b;
   word_t    issue_imm;
   word_t    issue_pc;
   logic     credit;
   logic     retire_valid;
   word_t    retire_pc;
   logic     retire_wb;
   reg_adr_t retire_rd;
   word_t    retire_data;
   logic     retire_flag;
   logic     exc_valid;
   exc_e     exc_cause;
   word_t    exc_pc;

   logic [31:0] cases [NUM_CASES*CASE_FIELDS];
   int          credits;
   int          issued;
   int          events;

   pipe_slice_top #(
      .QUEUE_DEPTH (QUEUE_DEPTH),
      .MEM_WORDS   (64),
      .SPR_LATENCY (2)
   ) u_pipe_slice_top (
      .clk            (clk),
      .rst            (rst),
      .issue_valid_i  (issue_valid),
      .issue_op_i     (issue_op),
      .issue_rd_i     (issue_rd),
      .issue_a_i      (issue_a),
      .issue_b_i      (issue_b),
      .issue_imm_i    (issue_imm),
      .issue_pc_i     (issue_pc),
      .credit_o       (credit),
      .retire_valid_o (retire_valid),
      .retire_pc_o    (retire_pc),
      .retire_wb_o    (retire_wb),
      .retire_rd_o    (retire_rd),
      .retire_data_o  (retire_data),
      .retire_flag_o  (retire_flag),
      .exc_valid_o    (exc_valid),
      .exc_cause_o    (exc_cause),
      .exc_pc_o       (exc_pc)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   function automatic logic [31:0] case_field(input int idx, input int col);
      return cases[idx*CASE_FIELDS + col];
   endfunction

   task automatic stop_run();
      $display("Some tests failed");
      $fatal(1, "simulation stopped at the first error");
   endtask

   task automatic abort_run(input string msg);
      $display("ERROR at time %0t: %s", $time, msg);
      stop_run();
   endtask

   task automatic check_value(input string what, input logic [31:0] got,
                              input logic [31:0] exp);
      if (got !== exp) begin
         $display("CHECK FAILED at time %0t: %s is %h, expected %h", $time, what, got, exp);
         stop_run();
      end
   endtask

   // events arrive in issue order, so each one belongs to the oldest unmatched case
   task automatic match_event();
      logic [31:0] kind;
      string       tag;
      if (events >= issued) begin
         abort_run("a retire or exception came with no instruction outstanding");
      end else begin
         tag  = $sformatf("case %0d", events);
         kind = exc_valid ? KIND_EXC : (retire_wb ? KIND_WB : KIND_NOWB);
         check_value({tag, " event kind"}, kind, case_field(events, COL_KIND));
         if (exc_valid) begin
            check_value({tag, " exception cause"}, 32'(exc_cause),
                        case_field(events, COL_CAUSE));
            check_value({tag, " exception pc"}, exc_pc, case_field(events, COL_PC));
         end else begin
            check_value({tag, " retire pc"}, retire_pc, case_field(events, COL_PC));
            check_value({tag, " flag"}, 32'(retire_flag), case_field(events, COL_FLAG));
            if (retire_wb) begin
               check_value({tag, " rd"}, 32'(retire_rd), case_field(events, COL_RD));
               check_value({tag, " data"}, retire_data, case_field(events, COL_DATA));
            end
         end
         events++;
      end
   endtask

   // outputs are registered, so the falling edge sees them settled
   task automatic next_cycle();
      @(negedge clk);
      if (credit) begin
         credits++;
         if (credits > QUEUE_DEPTH) begin
            abort_run("more credits came back than instructions were issued");
         end
      end
      if (retire_valid && exc_valid) begin
         abort_run("retire and exception were reported in the same cycle");
      end else if (retire_valid || exc_valid) begin
         match_event();
      end
      issue_valid = 1'b0;
   endtask

   task automatic issue_case(input int idx);
      logic [31:0] op_word;
      logic [31:0] rd_word;
      op_word     = case_field(idx, COL_OP);
      rd_word     = case_field(idx, COL_RD);
      issue_valid = 1'b1;
      issue_op    = op_e'(op_word[3:0]);
      issue_rd    = rd_word[4:0];
      issue_a     = case_field(idx, COL_A);
      issue_b     = case_field(idx, COL_B);
      issue_imm   = case_field(idx, COL_IMM);
      issue_pc    = case_field(idx, COL_PC);
      credits--;
      issued++;
   endtask

   task automatic wait_credit(input int idx);
      int waited;
      waited = 0;
      while (credits == 0) begin
         if (waited == TIMEOUT_CYCLES) begin
            abort_run($sformatf("no credit came back to issue case %0d", idx));
         end
         next_cycle();
         waited++;
      end
   endtask

   task automatic wait_drain(input int target, input string what);
      int waited;
      waited = 0;
      while ((events < target) || (credits != QUEUE_DEPTH)) begin
         if (waited == TIMEOUT_CYCLES) begin
            abort_run($sformatf("%s never came", what));
         end
         next_cycle();
         waited++;
      end
   endtask

   initial begin
      int idx;
      rst         = 1'b1;
      issue_valid = 1'b0;
      issue_op    = OP_ADD;
      issue_rd    = '0;
      issue_a     = '0;
      issue_b     = '0;
      issue_imm   = '0;
      issue_pc    = '0;
      credits     = 0;
      issued      = 0;
      events      = 0;
      $readmemh("verif/pipe_slice_cases.txt", cases);
      if (^case_field(NUM_CASES - 1, COL_CAUSE) === 1'bx) begin
         abort_run("the cases file is missing or incomplete");
      end
      repeat (16) @(negedge clk);
      rst     = 1'b0;
      credits = QUEUE_DEPTH;

      for (idx = 0; idx < NUM_CASES; idx++) begin
         wait_credit(idx);
         issue_case(idx);
         next_cycle();
         // nothing younger may sit in the queue when the flush hits
         if (case_field(idx, COL_KIND) == KIND_EXC) begin
            wait_drain(idx + 1,
                       $sformatf("the exception of case %0d with all credits back", idx));
         end
      end
      wait_drain(NUM_CASES, "the last retire with all credits back");
      $display("All tests passed");
      $finish;
   end

endmodule
